// File: include/pio_defines.svh
`ifndef PIO_DEFINES_SVH
`define PIO_DEFINES_SVH

// Block dimensions
`define PIO_NUM_SM      4
`define PIO_FIFO_DEPTH  4
`define PIO_MEM_WORDS   32

// Instruction fields
`define PIO_F_OP        15:13
`define PIO_F_SEL       7:5    // JMP condition, IN/OUT/SET/MOV target
`define PIO_F_DATA      4:0    // Bit count, SET data or JMP address
`define PIO_F_MOV_OP    4:3
`define PIO_F_MOV_SRC   2:0
`define PIO_B_PULL      7      // Set for PULL, clear for PUSH

// MOV operation codes
`define PIO_MOV_INVERT  2'b01

`endif

// File: hdl/pio_pkg.sv
package pio_pkg;

  // Host port actions
  typedef enum logic [3:0] {
    ACT_NONE  = 4'd0,
    ACT_INSTR = 4'd1,
    ACT_PEND  = 4'd2,
    ACT_PULL  = 4'd3,
    ACT_PUSH  = 4'd4,
    ACT_GRPS  = 4'd5,
    ACT_EN    = 4'd6
  } pio_action_e;

  // Supported instruction classes
  typedef enum logic [2:0] {
    OP_JMP      = 3'd0,
    OP_IN       = 3'd2,
    OP_OUT      = 3'd3,
    OP_PUSHPULL = 3'd4,
    OP_MOV      = 3'd5,
    OP_SET      = 3'd7
  } pio_opcode_e;

  typedef struct packed {
    logic [4:0] wrap_target;
    logic [4:0] pend;         // Last instruction before wrap
    logic [4:0] out_base;
    logic [5:0] out_count;
    logic [4:0] set_base;
    logic [2:0] set_count;
    logic [4:0] in_base;
    logic [4:0] jmp_pin;
  } sm_config_t;

  typedef struct packed {
    logic [31:0] values;
    logic [31:0] dirs;
    logic [31:0] mask;        // Pins owned by this machine
  } sm_pins_t;

endpackage

// File: hdl/pio_fifo.sv
`timescale 1ns/1ps
`include "pio_defines.svh"

module pio_fifo (
  input  logic        clk,
  input  logic        reset,
  input  logic        push,
  input  logic        pull,
  input  logic [31:0] din,
  output logic [31:0] dout,
  output logic        empty,
  output logic        full
);

  localparam int DEPTH = `PIO_FIFO_DEPTH;
  localparam int AW = $clog2(DEPTH);

  logic [31:0]   mem [DEPTH];
  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic [AW:0]   count;
  logic          do_push;
  logic          do_pull;

  function automatic logic [AW-1:0] ptr_inc(input logic [AW-1:0] p);
    return (p == AW'(DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  assign do_push = push && !full;
  assign do_pull = pull && !empty;
  assign empty = (count == '0);
  assign full = (count == (AW + 1)'(DEPTH));
  assign dout = mem[rd_ptr];  // Show-ahead head

  always_ff @(posedge clk) begin
    if (do_push) mem[wr_ptr] <= din;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
    end else begin
      if (do_push) wr_ptr <= ptr_inc(wr_ptr);
      if (do_pull) rd_ptr <= ptr_inc(rd_ptr);
      if (do_push && !do_pull) count <= count + 1'b1;
      else if (do_pull && !do_push) count <= count - 1'b1;
    end
  end

endmodule

// File: hdl/pio_host_regs.sv
`timescale 1ns/1ps
`include "pio_defines.svh"

module pio_host_regs (
  input  logic                    clk,
  input  logic                    reset,
  input  pio_pkg::pio_action_e    action,
  input  logic [1:0]              mindex,
  input  logic [4:0]              index,
  input  logic [31:0]             din,
  output logic [31:0]             dout,
  input  logic [4:0]              pcs      [`PIO_NUM_SM],
  output logic [15:0]             instrs   [`PIO_NUM_SM],
  output pio_pkg::sm_config_t     configs  [`PIO_NUM_SM],
  output logic [`PIO_NUM_SM-1:0]  en,
  output logic [`PIO_NUM_SM-1:0]  restart,
  output logic [`PIO_NUM_SM-1:0]  tx_push,
  output logic [`PIO_NUM_SM-1:0]  rx_pull,
  input  logic [31:0]             rx_heads [`PIO_NUM_SM]
);

  logic [15:0] mem [`PIO_MEM_WORDS];  // Shared program memory

  always_ff @(posedge clk) begin
    if (action == pio_pkg::ACT_INSTR) mem[index] <= din[15:0];
  end

  // One fetch port per machine
  always_comb begin
    for (int m = 0; m < `PIO_NUM_SM; m++) begin
      instrs[m] = mem[pcs[m]];
    end
  end

  // FIFO strobes line up with din
  always_comb begin
    tx_push = '0;
    rx_pull = '0;
    if (action == pio_pkg::ACT_PUSH) tx_push[mindex] = 1'b1;
    if (action == pio_pkg::ACT_PULL) rx_pull[mindex] = 1'b1;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      dout <= '0;
      en <= '0;
      restart <= '0;
      for (int m = 0; m < `PIO_NUM_SM; m++) begin
        configs[m] <= '0;
      end
    end else begin
      restart <= '0;  // Single-cycle pulse
      case (action)
        pio_pkg::ACT_PEND: begin
          configs[mindex].wrap_target <= din[11:7];
          configs[mindex].pend <= din[16:12];
          configs[mindex].jmp_pin <= din[28:24];
        end
        pio_pkg::ACT_GRPS: begin
          configs[mindex].out_base <= din[4:0];
          configs[mindex].set_base <= din[9:5];
          configs[mindex].in_base <= din[19:15];
          configs[mindex].out_count <= din[25:20];
          configs[mindex].set_count <= din[28:26];
        end
        pio_pkg::ACT_EN: begin
          en <= din[`PIO_NUM_SM-1:0];
          restart <= din[2*`PIO_NUM_SM-1:`PIO_NUM_SM];
        end
        pio_pkg::ACT_PULL: dout <= rx_heads[mindex];  // Head before the pop
        default: ;
      endcase
    end
  end

endmodule

// File: hdl/pio_machine.sv
`timescale 1ns/1ps
`include "pio_defines.svh"

module pio_machine (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 en,
  input  logic                 restart,
  input  pio_pkg::sm_config_t  cfg,
  input  logic [15:0]          instr,
  output logic [4:0]           pc,
  input  logic [31:0]          gpio_in,
  input  logic [31:0]          tx_data,
  input  logic                 tx_empty,
  output logic                 tx_pull,
  output logic [31:0]          rx_data,
  input  logic                 rx_full,
  output logic                 rx_push,
  output pio_pkg::sm_pins_t    pins
);

  logic [31:0]          x, y, isr, osr;
  logic [5:0]           osr_count;
  logic [31:0]          pin_vals, pin_dirs;
  pio_pkg::pio_opcode_e op;
  logic [2:0]           sel;
  logic [4:0]           data;
  logic [5:0]           bit_count;
  logic [31:0]          bit_mask;
  logic [31:0]          in_pins, out_mask, set_mask;
  logic [31:0]          in_word, out_word, mov_word, set_word;
  logic [6:0]           osr_sum;
  logic                 jmp_cond, take_jmp, stall;
  logic [4:0]           pc_next;

  function automatic logic [31:0] rotl(input logic [31:0] v, input logic [4:0] n);
    logic [63:0] w;
    w = {v, v} << n;
    return w[63:32];
  endfunction

  function automatic logic [31:0] rotr(input logic [31:0] v, input logic [4:0] n);
    logic [63:0] w;
    w = {v, v} >> n;
    return w[31:0];
  endfunction

  function automatic logic [31:0] src_value(input logic [2:0] s);
    case (s)
      3'd0: return in_pins;
      3'd1: return x;
      3'd2: return y;
      3'd6: return isr;
      3'd7: return osr;
      default: return 32'd0;  // Null
    endcase
  endfunction

  assign op = pio_pkg::pio_opcode_e'(instr[`PIO_F_OP]);
  assign sel = instr[`PIO_F_SEL];
  assign data = instr[`PIO_F_DATA];
  assign bit_count = (data == 5'd0) ? 6'd32 : {1'b0, data};  // Zero means 32
  assign bit_mask = ~(32'hffff_ffff << bit_count);
  assign in_pins = rotr(gpio_in, cfg.in_base);
  assign out_mask = rotl(~(32'hffff_ffff << cfg.out_count), cfg.out_base);
  assign set_mask = rotl(~(32'hffff_ffff << cfg.set_count), cfg.set_base);
  assign out_word = osr & bit_mask;
  assign set_word = rotl({27'd0, data}, cfg.set_base) & set_mask;
  assign osr_sum = {1'b0, osr_count} + {1'b0, bit_count};

  always_comb begin
    in_word = src_value(sel) & bit_mask;
    mov_word = src_value(instr[`PIO_F_MOV_SRC]);
    if (instr[`PIO_F_MOV_OP] == `PIO_MOV_INVERT) mov_word = ~mov_word;
  end

  always_comb begin
    case (sel)
      3'd0: jmp_cond = 1'b1;
      3'd1: jmp_cond = (x == 32'd0);
      3'd2: jmp_cond = (x != 32'd0);  // X-- tests before decrement
      3'd3: jmp_cond = (y == 32'd0);
      3'd4: jmp_cond = (y != 32'd0);
      3'd5: jmp_cond = (x != y);
      3'd6: jmp_cond = gpio_in[cfg.jmp_pin];
      default: jmp_cond = (osr_count < 6'd32);  // OSR not empty
    endcase
  end

  always_comb begin
    tx_pull = 1'b0;
    rx_push = 1'b0;
    stall = 1'b0;
    if (op == pio_pkg::OP_PUSHPULL) begin
      if (instr[`PIO_B_PULL]) begin
        stall = tx_empty;
        tx_pull = en && !restart && !tx_empty;
      end else begin
        stall = rx_full;
        rx_push = en && !restart && !rx_full;
      end
    end
    take_jmp = (op == pio_pkg::OP_JMP) && jmp_cond;
    if (stall) pc_next = pc;
    else if (take_jmp) pc_next = data;
    else if (pc == cfg.pend) pc_next = cfg.wrap_target;
    else pc_next = pc + 5'd1;
  end

  always_ff @(posedge clk) begin
    if (reset || restart) begin
      pc <= '0;
      x <= '0;
      y <= '0;
      isr <= '0;
      osr <= '0;
      osr_count <= '0;
      if (reset) begin
        pin_vals <= '0;
        pin_dirs <= '0;
      end
    end else if (en && !stall) begin
      pc <= pc_next;
      case (op)
        pio_pkg::OP_JMP: begin
          if (sel == 3'd2) x <= x - 32'd1;
          if (sel == 3'd4) y <= y - 32'd1;
        end
        pio_pkg::OP_IN: begin
          isr <= (isr << bit_count) | in_word;
        end
        pio_pkg::OP_OUT: begin
          osr <= osr >> bit_count;
          osr_count <= (osr_sum > 7'd32) ? 6'd32 : osr_sum[5:0];
          case (sel)
            3'd0: pin_vals <= (pin_vals & ~out_mask) | (rotl(out_word, cfg.out_base) & out_mask);
            3'd1: x <= out_word;
            3'd2: y <= out_word;
            default: ;
          endcase
        end
        pio_pkg::OP_PUSHPULL: begin
          if (instr[`PIO_B_PULL]) begin
            osr <= tx_data;
            osr_count <= '0;
          end else begin
            isr <= '0;  // rx_data carries the old ISR
          end
        end
        pio_pkg::OP_MOV: begin
          case (sel)
            3'd0: pin_vals <= (pin_vals & ~out_mask) | (rotl(mov_word, cfg.out_base) & out_mask);
            3'd1: x <= mov_word;
            3'd2: y <= mov_word;
            3'd6: isr <= mov_word;
            3'd7: begin
              osr <= mov_word;
              osr_count <= '0;
            end
            default: ;
          endcase
        end
        pio_pkg::OP_SET: begin
          case (sel)
            3'd0: pin_vals <= (pin_vals & ~set_mask) | set_word;
            3'd1: x <= {27'd0, data};
            3'd2: y <= {27'd0, data};
            3'd4: pin_dirs <= (pin_dirs & ~set_mask) | set_word;
            default: ;
          endcase
        end
        default: ;
      endcase
    end
  end

  assign rx_data = isr;
  assign pins.values = pin_vals;
  assign pins.dirs = pin_dirs;
  assign pins.mask = out_mask | set_mask;

endmodule

// File: hdl/pio_pin_merge.sv
`timescale 1ns/1ps
`include "pio_defines.svh"

module pio_pin_merge (
  input  pio_pkg::sm_pins_t pins_in [`PIO_NUM_SM],
  output logic [31:0]       gpio_out,
  output logic [31:0]       gpio_dir
);

  logic [31:0] out_acc;
  logic [31:0] dir_acc;

  // Ascending walk, so the highest machine ends up owning a shared pin
  always_comb begin
    out_acc = '0;
    dir_acc = '0;
    for (int m = 0; m < `PIO_NUM_SM; m++) begin
      out_acc = (out_acc & ~pins_in[m].mask) | (pins_in[m].values & pins_in[m].mask);
      dir_acc = (dir_acc & ~pins_in[m].mask) | (pins_in[m].dirs & pins_in[m].mask);
    end
  end

  assign gpio_out = out_acc;
  assign gpio_dir = dir_acc;  // Zero where no group covers the pin

endmodule

// File: hdl/pio.sv
`timescale 1ns/1ps
`include "pio_defines.svh"

module pio (
  input  logic                    clk,
  input  logic                    reset,
  input  pio_pkg::pio_action_e    action,
  input  logic [1:0]              mindex,
  input  logic [4:0]              index,
  input  logic [31:0]             din,
  output logic [31:0]             dout,
  input  logic [31:0]             gpio_in,
  output logic [31:0]             gpio_out,
  output logic [31:0]             gpio_dir,
  output logic [`PIO_NUM_SM-1:0]  tx_full,
  output logic [`PIO_NUM_SM-1:0]  rx_empty
);

  logic [4:0]              pcs       [`PIO_NUM_SM];
  logic [15:0]             instrs    [`PIO_NUM_SM];
  pio_pkg::sm_config_t     configs   [`PIO_NUM_SM];
  logic [31:0]             rx_heads  [`PIO_NUM_SM];
  logic [31:0]             tx_heads  [`PIO_NUM_SM];
  logic [31:0]             sm_rx_data [`PIO_NUM_SM];
  pio_pkg::sm_pins_t       sm_pins   [`PIO_NUM_SM];
  logic [`PIO_NUM_SM-1:0]  en;
  logic [`PIO_NUM_SM-1:0]  restart;
  logic [`PIO_NUM_SM-1:0]  tx_push;
  logic [`PIO_NUM_SM-1:0]  rx_pull;
  logic [`PIO_NUM_SM-1:0]  tx_empty_sm;
  logic [`PIO_NUM_SM-1:0]  rx_full_sm;
  logic [`PIO_NUM_SM-1:0]  sm_tx_pull;
  logic [`PIO_NUM_SM-1:0]  sm_rx_push;

  pio_host_regs i_host_regs (
    .clk      (clk),
    .reset    (reset),
    .action   (action),
    .mindex   (mindex),
    .index    (index),
    .din      (din),
    .dout     (dout),
    .pcs      (pcs),
    .instrs   (instrs),
    .configs  (configs),
    .en       (en),
    .restart  (restart),
    .tx_push  (tx_push),
    .rx_pull  (rx_pull),
    .rx_heads (rx_heads)
  );

  for (genvar m = 0; m < `PIO_NUM_SM; m++) begin : g_sm
    pio_machine i_machine (
      .clk      (clk),
      .reset    (reset),
      .en       (en[m]),
      .restart  (restart[m]),
      .cfg      (configs[m]),
      .instr    (instrs[m]),
      .pc       (pcs[m]),
      .gpio_in  (gpio_in),
      .tx_data  (tx_heads[m]),
      .tx_empty (tx_empty_sm[m]),
      .tx_pull  (sm_tx_pull[m]),
      .rx_data  (sm_rx_data[m]),
      .rx_full  (rx_full_sm[m]),
      .rx_push  (sm_rx_push[m]),
      .pins     (sm_pins[m])
    );

    pio_fifo i_tx_fifo (  // Host to machine
      .clk   (clk),
      .reset (reset),
      .push  (tx_push[m]),
      .pull  (sm_tx_pull[m]),
      .din   (din),
      .dout  (tx_heads[m]),
      .empty (tx_empty_sm[m]),
      .full  (tx_full[m])
    );

    pio_fifo i_rx_fifo (  // Machine to host
      .clk   (clk),
      .reset (reset),
      .push  (sm_rx_push[m]),
      .pull  (rx_pull[m]),
      .din   (sm_rx_data[m]),
      .dout  (rx_heads[m]),
      .empty (rx_empty[m]),
      .full  (rx_full_sm[m])
    );
  end

  pio_pin_merge i_pin_merge (
    .pins_in  (sm_pins),
    .gpio_out (gpio_out),
    .gpio_dir (gpio_dir)
  );

endmodule

// File: tb/tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
  parameter int HALF_PERIOD_NS = 50
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
    forever #(HALF_PERIOD_NS) clk = ~clk;  // 100 ns period
  end

endmodule

// File: tb/pio_tb.sv
`timescale 1ns/1ps
`include "pio_defines.svh"

module pio_tb;

  localparam int LINE_CHARS = 120;

  logic                    clk;
  logic                    reset;
  pio_pkg::pio_action_e    action;
  logic [1:0]              mindex;
  logic [4:0]              index;
  logic [31:0]             din;
  logic [31:0]             dout;
  logic [31:0]             gpio_in;
  logic [31:0]             gpio_out;
  logic [31:0]             gpio_dir;
  logic [`PIO_NUM_SM-1:0]  tx_full;
  logic [`PIO_NUM_SM-1:0]  rx_empty;

  logic [63:0] cmd_op     [$];
  logic [31:0] cmd_mindex [$];
  logic [31:0] cmd_index  [$];
  logic [31:0] cmd_value  [$];
  logic [31:0] cmd_expect [$];
  int          errors;
  int          checks;
  int          cycle_limit;
  int          cycle_count;

  tb_clock i_clock (
    .clk (clk)
  );

  pio i_pio (
    .clk      (clk),
    .reset    (reset),
    .action   (action),
    .mindex   (mindex),
    .index    (index),
    .din      (din),
    .dout     (dout),
    .gpio_in  (gpio_in),
    .gpio_out (gpio_out),
    .gpio_dir (gpio_dir),
    .tx_full  (tx_full),
    .rx_empty (rx_empty)
  );

  task automatic tick();
    @(posedge clk);
    #1;  // Drive point
  endtask

  task automatic host_action(input pio_pkg::pio_action_e act, input logic [31:0] m,
                             input logic [31:0] idx, input logic [31:0] val);
    action = act;
    mindex = m[1:0];
    index = idx[4:0];
    din = val;
    tick();
    action = pio_pkg::ACT_NONE;
  endtask

  task automatic pull_and_check(input logic [31:0] m, input logic [31:0] exp);
    while (rx_empty[m[1:0]]) tick();  // Watchdog ends a hung wait
    host_action(pio_pkg::ACT_PULL, m, 32'd0, 32'd0);
    checks++;
    if (dout !== exp) begin
      errors++;
      $display("mismatch dout (machine %0d): got %h expected %h", m, dout, exp);
    end
  endtask

  task automatic load_commands(output bit ok);
    int                      fd;
    int                      n;
    logic [8*LINE_CHARS-1:0] line;
    logic [63:0]             op;
    logic [31:0]             m, idx, val, exp;
    ok = 1'b1;
    fd = $fopen("tb/pio_testdata.txt", "r");
    if (fd == 0) begin
      ok = 1'b0;
      return;
    end
    while (!$feof(fd)) begin
      line = '0;
      n = $fgets(line, fd);
      if (n > 0) begin
        n = $sscanf(line, "%s %h %h %h %h", op, m, idx, val, exp);
        if (n == 5) begin
          cmd_op.push_back(op);
          cmd_mindex.push_back(m);
          cmd_index.push_back(idx);
          cmd_value.push_back(val);
          cmd_expect.push_back(exp);
        end else if (n > 0 && op != "#") begin
          $display("test data line could not be read: %0s", line);
          ok = 1'b0;
        end
      end
    end
    $fclose(fd);
  endtask

  task automatic run_command(input logic [63:0] op, input logic [31:0] m,
                             input logic [31:0] idx, input logic [31:0] val,
                             input logic [31:0] exp);
    if (op == "INSTR") host_action(pio_pkg::ACT_INSTR, m, idx, val);
    else if (op == "PEND") host_action(pio_pkg::ACT_PEND, m, idx, val);
    else if (op == "GRPS") host_action(pio_pkg::ACT_GRPS, m, idx, val);
    else if (op == "EN") host_action(pio_pkg::ACT_EN, m, idx, val);
    else if (op == "PUSH") host_action(pio_pkg::ACT_PUSH, m, idx, val);
    else if (op == "GPIN") gpio_in = val;
    else if (op == "IDLE") repeat (val) tick();
    else if (op == "RXCHK") pull_and_check(m, exp);
    else if (op == "PINS") begin
      checks += 2;
      if (gpio_out !== val) begin
        errors++;
        $display("mismatch gpio_out: got %h expected %h", gpio_out, val);
      end
      if (gpio_dir !== exp) begin
        errors++;
        $display("mismatch gpio_dir: got %h expected %h", gpio_dir, exp);
      end
    end else if (op == "LEVEL") begin
      checks += 2;
      if (tx_full !== val[`PIO_NUM_SM-1:0]) begin
        errors++;
        $display("mismatch tx_full: got %h expected %h", tx_full, val[`PIO_NUM_SM-1:0]);
      end
      if (rx_empty !== exp[`PIO_NUM_SM-1:0]) begin
        errors++;
        $display("mismatch rx_empty: got %h expected %h", rx_empty, exp[`PIO_NUM_SM-1:0]);
      end
    end else begin
      errors++;
      $display("unknown command in test data: %0s", op);
    end
  endtask

  initial begin : watchdog
    cycle_count = 0;
    @(posedge clk);
    while (cycle_limit == 0 || cycle_count < cycle_limit) begin
      @(posedge clk);
      cycle_count++;
    end
    errors++;
    $display("timeout: the test did not finish within %0d clock cycles", cycle_limit);
    $display("checks: %0d  errors: %0d", checks, errors);
    $display("RESULT: FAIL");
    $finish;
  end

  initial begin : main
    bit loaded;
    action = pio_pkg::ACT_NONE;
    mindex = '0;
    index = '0;
    din = '0;
    gpio_in = '0;
    reset = 1'b1;
    errors = 0;
    checks = 0;
    cycle_limit = 0;
    load_commands(loaded);
    if (!loaded) begin
      errors++;
      $display("the test data file could not be read completely");
    end
    cycle_limit = 20 * cmd_op.size() + 200;
    repeat (5) @(posedge clk);
    #1;
    reset = 1'b0;
    for (int i = 0; i < cmd_op.size(); i++) begin
      run_command(cmd_op[i], cmd_mindex[i], cmd_index[i], cmd_value[i], cmd_expect[i]);
    end
    tick();
    $display("checks: %0d  errors: %0d", checks, errors);
    if (errors == 0)
      $display("RESULT: PASS");
    else
      $display("RESULT: FAIL");
    $finish;
  end

endmodule

// File: tb/pio_testdata.txt
# op mindex index value expected, numbers in hex
# PINS: value is gpio_out and expected is gpio_dir; LEVEL: value is tx_full, expected rx_empty
# echo on machine 0: PULL, OUT X 32, IN X 32, PUSH
INSTR 0 00 00008080 0
INSTR 0 01 00006020 0
INSTR 0 02 00004020 0
INSTR 0 03 00008000 0
PEND  0 00 00003000 0
EN    0 00 00000011 0
PUSH  0 00 11223344 0
PUSH  0 00 deadbeef 0
PUSH  0 00 0badf00d 0
RXCHK 0 00 00000000 11223344
RXCHK 0 00 00000000 deadbeef
RXCHK 0 00 00000000 0badf00d
EN    0 00 00000000 0
# loop count on machine 1: SET X 3, IN X 32, PUSH, JMP X-- 1, PULL
INSTR 0 00 0000e023 0
INSTR 0 01 00004020 0
INSTR 0 02 00008000 0
INSTR 0 03 00000041 0
INSTR 0 04 00008080 0
PEND  1 00 00004200 0
EN    0 00 00000022 0
RXCHK 1 00 00000000 00000003
RXCHK 1 00 00000000 00000002
RXCHK 1 00 00000000 00000001
RXCHK 1 00 00000000 00000000
EN    0 00 00000000 0
# pin groups on machine 0: SET pindirs 5, SET pins 5, set_base 4, set_count 3
INSTR 0 00 0000e085 0
INSTR 0 01 0000e005 0
INSTR 0 02 00000002 0
GRPS  0 00 0c000080 0
PEND  0 00 00002100 0
EN    0 00 00000011 0
IDLE  0 00 00000004 0
PINS  0 00 00000050 00000050
EN    0 00 00000000 0
# input pins on machine 0 with in_base 8: IN pins 32, PUSH, PULL
GPIN  0 00 12345678 0
GRPS  0 00 0c040080 0
INSTR 0 00 00004000 0
INSTR 0 01 00008000 0
INSTR 0 02 00008080 0
EN    0 00 00000011 0
RXCHK 0 00 00000000 78123456
EN    0 00 00000000 0
# priority: machine 1 sets a to pins 11..8, then machine 2 sets 5 there
INSTR 0 00 0000e00a 0
INSTR 0 01 00000001 0
PEND  1 00 00001080 0
GRPS  1 00 10000100 0
EN    0 00 00000022 0
IDLE  0 00 00000004 0
PINS  0 00 00000a50 00000050
EN    0 00 00000000 0
INSTR 0 00 0000e005 0
PEND  2 00 00001080 0
GRPS  2 00 10000100 0
EN    0 00 00000044 0
IDLE  0 00 00000004 0
PINS  0 00 00000550 00000050
EN    0 00 00000000 0
# levels: machine 3 disabled, four pushes fill its tx FIFO, a fifth is dropped
LEVEL 0 00 00000000 0000000f
PUSH  3 00 00000001 0
PUSH  3 00 00000002 0
PUSH  3 00 00000003 0
PUSH  3 00 00000004 0
LEVEL 0 00 00000008 0000000f
PUSH  3 00 00000005 0
LEVEL 0 00 00000008 0000000f

// File: verilog.f
+incdir+include
hdl/pio_pkg.sv
hdl/pio_fifo.sv
hdl/pio_host_regs.sv
hdl/pio_machine.sv
hdl/pio_pin_merge.sv
hdl/pio.sv
tb/tb_clock.sv
tb/pio_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the PIO testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing -j 0 --top-module pio_tb -f verilog.f -o pio_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/pio_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "^RESULT: PASS$" "$LOG"; then
  exit 0
fi
exit 1
